// File: verilog/mips_defs.svh
// Core widths, data RAM depth and output port address
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath word
`define MIPS_DATA_WIDTH 32

// Register index for 32 entries
`define MIPS_REG_ADDR_WIDTH 5

// Data RAM depth in words
`define MIPS_DMEM_WORDS 64

// Byte address of the output port above the RAM range
`define MIPS_IO_ADDR 32'd256

`endif

// File: verilog/mips_pkg.sv
// Opcode, funct, ALU operation and control state types
package mips_pkg;

    // Instruction [31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // Instruction [5:0], R-type only
    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT // Signed compare
    } alu_op_t;

    // Multicycle sequence
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM_ACCESS,
        S_WRITEBACK
    } state_t;

endpackage

// File: verilog/mips_regfile.sv
// Register file, 32 words, two async reads and one sync write
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_reg1,  // rs
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_reg2,  // rt
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] write_reg,
    input  logic [`MIPS_DATA_WIDTH-1:0]     write_data,
    input  logic                            write_en,
    output logic [`MIPS_DATA_WIDTH-1:0]     read_data1,
    output logic [`MIPS_DATA_WIDTH-1:0]     read_data2
);

    localparam int NUM_REGS = 1 << `MIPS_REG_ADDR_WIDTH;

    logic [`MIPS_DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (write_en && write_reg != '0) begin // $zero never written
            regs[write_reg] <= write_data;
        end
    end

    assign read_data1 = regs[read_reg1];
    assign read_data2 = regs[read_reg2];

endmodule

// File: verilog/mips_alu.sv
// Combinational ALU with zero flag
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_alu import mips_pkg::*; (
    input  logic [`MIPS_DATA_WIDTH-1:0] src_a,
    input  logic [`MIPS_DATA_WIDTH-1:0] src_b,
    input  alu_op_t                     op,
    output logic [`MIPS_DATA_WIDTH-1:0] result,
    output logic                        zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = src_a + src_b;
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLT: begin
                // Two's complement compare
                result = ($signed(src_a) < $signed(src_b)) ? `MIPS_DATA_WIDTH'(1) : '0;
            end
            default: result = '0;
        endcase
    end

    // beq taken when A - B is zero
    assign zero = (result == '0);

endmodule

// File: verilog/mips_control.sv
// Multicycle control FSM with select and enable decode
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  opcode_t    opcode,
    input  funct_t     funct,
    output logic       ir_write,
    output logic       pc_write,
    output logic       branch,
    output logic [1:0] pc_src,    // 0 ALU result, 1 ALU-out reg, 2 jump target
    output logic       alu_src_a, // 0 PC, 1 reg A
    output logic [1:0] alu_src_b, // 0 B, 1 const 4, 2 imm, 3 imm x4
    output alu_op_t    alu_op,
    output logic       reg_dst,   // 1 selects rd
    output logic       mem_to_reg,
    output logic       reg_write,
    output logic       mem_write
);

    state_t state, state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= S_FETCH;
        else        state <= state_nxt;
    end

    // Opcode steers the path out of decode, execute and mem_access
    always_comb begin
        state_nxt = S_FETCH;
        case (state)
            S_FETCH:  state_nxt = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_J: state_nxt = S_EXECUTE;
                    default: state_nxt = S_FETCH; // Unknown opcode acts as no-op
                endcase
            end
            S_EXECUTE: begin
                case (opcode)
                    OP_RTYPE, OP_ADDI: state_nxt = S_WRITEBACK;
                    OP_LW, OP_SW:      state_nxt = S_MEM_ACCESS;
                    default:           state_nxt = S_FETCH; // beq and j done
                endcase
            end
            S_MEM_ACCESS: state_nxt = (opcode == OP_LW) ? S_WRITEBACK : S_FETCH;
            default:      state_nxt = S_FETCH;
        endcase
    end

    always_comb begin
        ir_write   = 1'b0;
        pc_write   = 1'b0;
        branch     = 1'b0;
        pc_src     = 2'd0;
        alu_src_a  = 1'b0;
        alu_src_b  = 2'd0;
        alu_op     = ALU_ADD;
        reg_dst    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        case (state)
            S_FETCH: begin
                ir_write  = 1'b1;
                pc_write  = 1'b1;
                alu_src_b = 2'd1; // PC + 4
            end
            S_DECODE: alu_src_b = 2'd3; // Branch target into ALU-out
            S_EXECUTE: begin
                case (opcode)
                    OP_RTYPE: begin
                        alu_src_a = 1'b1;
                        case (funct)
                            FN_SUB:  alu_op = ALU_SUB;
                            FN_AND:  alu_op = ALU_AND;
                            FN_OR:   alu_op = ALU_OR;
                            FN_SLT:  alu_op = ALU_SLT;
                            default: alu_op = ALU_ADD;
                        endcase
                    end
                    OP_ADDI, OP_LW, OP_SW: begin
                        alu_src_a = 1'b1;
                        alu_src_b = 2'd2; // A + imm
                    end
                    OP_BEQ: begin
                        alu_src_a = 1'b1;
                        alu_op    = ALU_SUB; // Zero on equal
                        branch    = 1'b1;
                        pc_src    = 2'd1;
                    end
                    OP_J: begin
                        pc_write = 1'b1;
                        pc_src   = 2'd2;
                    end
                    default: ;
                endcase
            end
            S_MEM_ACCESS: mem_write = (opcode == OP_SW);
            S_WRITEBACK: begin
                reg_write  = 1'b1;
                reg_dst    = (opcode == OP_RTYPE);
                mem_to_reg = (opcode == OP_LW);
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/mips_datapath.sv
// Multicycle datapath with PC, IR, MDR, A/B and ALU-out registers and operand muxes
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_datapath import mips_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`MIPS_DATA_WIDTH-1:0] instr_data, // From external ROM in the same cycle
    input  logic [`MIPS_DATA_WIDTH-1:0] mem_rdata,
    input  logic                        ir_write,
    input  logic                        pc_write,
    input  logic                        branch,
    input  logic [1:0]                  pc_src,
    input  logic                        alu_src_a,
    input  logic [1:0]                  alu_src_b,
    input  alu_op_t                     alu_op,
    input  logic                        reg_dst,
    input  logic                        mem_to_reg,
    input  logic                        reg_write,
    output opcode_t                     opcode,
    output funct_t                      funct,
    output logic [`MIPS_DATA_WIDTH-1:0] instr_addr,
    output logic [`MIPS_DATA_WIDTH-1:0] mem_addr,
    output logic [`MIPS_DATA_WIDTH-1:0] mem_wdata
);

    logic [`MIPS_DATA_WIDTH-1:0] pc, ir, mdr, reg_a, reg_b, alu_out;
    logic [`MIPS_DATA_WIDTH-1:0] rd_data1, rd_data2, wr_data;
    logic [`MIPS_DATA_WIDTH-1:0] src_a, src_b, alu_result, pc_next;
    logic [`MIPS_DATA_WIDTH-1:0] imm_ext, imm_x4, jump_addr;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] wr_reg;
    logic zero;
    logic pc_en;

    // Instruction fields
    assign opcode    = opcode_t'(ir[31:26]);
    assign funct     = funct_t'(ir[5:0]);
    assign imm_ext   = {{(`MIPS_DATA_WIDTH-16){ir[15]}}, ir[15:0]};
    assign imm_x4    = {imm_ext[`MIPS_DATA_WIDTH-3:0], 2'b00};
    assign jump_addr = {pc[31:28], ir[25:0], 2'b00}; // PC already +4

    // Program counter and instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pc_en)    pc <= pc_next;
            if (ir_write) ir <= instr_data;
        end
    end

    // Staging registers load every cycle
    always_ff @(posedge clk) begin
        reg_a   <= rd_data1;
        reg_b   <= rd_data2;
        alu_out <= alu_result;
        mdr     <= mem_rdata;
    end

    assign wr_reg  = reg_dst ? ir[15:11] : ir[20:16];
    assign wr_data = mem_to_reg ? mdr : alu_out;

    mips_regfile rf0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_reg1  (ir[25:21]),
        .read_reg2  (ir[20:16]),
        .write_reg  (wr_reg),
        .write_data (wr_data),
        .write_en   (reg_write),
        .read_data1 (rd_data1),
        .read_data2 (rd_data2)
    );

    assign src_a = alu_src_a ? reg_a : pc;

    always_comb begin
        case (alu_src_b)
            2'd0:    src_b = reg_b;
            2'd1:    src_b = `MIPS_DATA_WIDTH'(4); // Next sequential PC
            2'd2:    src_b = imm_ext;
            default: src_b = imm_x4;               // Branch offset
        endcase
    end

    mips_alu alu0 (
        .src_a  (src_a),
        .src_b  (src_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    always_comb begin
        case (pc_src)
            2'd1:    pc_next = alu_out;   // Target from decode
            2'd2:    pc_next = jump_addr;
            default: pc_next = alu_result;
        endcase
    end

    assign pc_en = pc_write | (branch & zero); // Branch condition lives here only

    assign instr_addr = pc;
    assign mem_addr   = alu_out;
    assign mem_wdata  = reg_b;

endmodule

// File: verilog/mips_data_mem.sv
// Data RAM with output port decode and registered strobe
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_data_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mem_write,
    input  logic [`MIPS_DATA_WIDTH-1:0] mem_addr,  // Byte address
    input  logic [`MIPS_DATA_WIDTH-1:0] mem_wdata,
    output logic [`MIPS_DATA_WIDTH-1:0] mem_rdata,
    output logic                        io_we,
    output logic [7:0]                  io_data
);

    localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_DATA_WIDTH-1:0] ram [`MIPS_DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic is_io;

    assign idx   = mem_addr[IDX_W+1:2]; // Word index wraps at depth
    assign is_io = (mem_addr == `MIPS_IO_ADDR);

    always_ff @(posedge clk) begin
        if (mem_write && !is_io) ram[idx] <= mem_wdata;
    end

    assign mem_rdata = is_io ? '0 : ram[idx]; // Port reads back zero

    // One-cycle strobe after the store and data held until the next store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_we   <= 1'b0;
            io_data <= '0;
        end else begin
            io_we <= mem_write & is_io;
            if (mem_write && is_io) io_data <= mem_wdata[7:0];
        end
    end

endmodule

// File: verilog/mips_top.sv
// Core top level: control FSM, datapath and data memory
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_top import mips_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`MIPS_DATA_WIDTH-1:0] instr_data,
    output logic [`MIPS_DATA_WIDTH-1:0] instr_addr,
    output logic                        io_we,
    output logic [7:0]                  io_data
);

    logic ir_write, pc_write, branch, alu_src_a;
    logic reg_dst, mem_to_reg, reg_write, mem_write;
    logic [1:0] pc_src, alu_src_b;
    alu_op_t alu_op;
    opcode_t opcode;
    funct_t  funct;
    logic [`MIPS_DATA_WIDTH-1:0] mem_addr, mem_wdata, mem_rdata;

    mips_control ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .funct      (funct),
        .ir_write   (ir_write),
        .pc_write   (pc_write),
        .branch     (branch),
        .pc_src     (pc_src),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .alu_op     (alu_op),
        .reg_dst    (reg_dst),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_write  (mem_write)
    );

    mips_datapath dp0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_data (instr_data),
        .mem_rdata  (mem_rdata),
        .ir_write   (ir_write),
        .pc_write   (pc_write),
        .branch     (branch),
        .pc_src     (pc_src),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .alu_op     (alu_op),
        .reg_dst    (reg_dst),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .opcode     (opcode),
        .funct      (funct),
        .instr_addr (instr_addr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    mips_data_mem dmem0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .io_we     (io_we),
        .io_data   (io_data)
    );

endmodule

// File: test/tb_mips.sv
// Testbench for mips_top with ROM model, check task, directed tests and watchdog
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 6;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 2000 * CLK_PERIOD;
    localparam int OPC_J = 2, OPC_BEQ = 4, OPC_ADDI = 8, OPC_LW = 35, OPC_SW = 43;
    localparam int FN_ADD = 32, FN_SUB = 34, FN_AND = 36, FN_OR = 37, FN_SLT = 42;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_data;
    logic [31:0] instr_addr;
    logic        io_we;
    logic [7:0]  io_data;

    logic [31:0] rom [256];    // Instruction ROM model indexed by word
    logic [31:0] prog [$];     // Program of the current test
    logic [7:0]  exp_bytes [$]; // Expected io_data sequence
    integer      seed;

    mips_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_data (instr_data),
        .instr_addr (instr_addr),
        .io_we      (io_we),
        .io_data    (io_data)
    );

    assign instr_data = rom[instr_addr[9:2]]; // Answers in the same cycle

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
                                           input int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
    endfunction

    function automatic logic [31:0] i_type(input int op, input int rs, input int rt,
                                           input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] j_type(input int word_idx);
        return {6'(OPC_J), 26'(word_idx)};
    endfunction

    // Store register r to the output port
    function automatic logic [31:0] store_io(input int r);
        return i_type(OPC_SW, 0, r, `MIPS_IO_ADDR);
    endfunction

    task automatic stop_with_error(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "test stopped");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Fail %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Reset held 5 cycles while the ROM is reloaded
    task automatic start_program();
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) rom[i] = {6'h3f, 18'h0, 8'(i)}; // Unknown opcode acts as no-op
        foreach (prog[i]) rom[i] = prog[i];
        rom[prog.size()] = j_type(prog.size()); // Park on a jump to itself
        repeat (5) begin
            @(negedge clk);
            check({31'd0, io_we}, 32'd0, "io_we during reset");
            check(instr_addr, 32'd0, "instr_addr during reset");
        end
        rst_n = 1'b1;
    endtask

    task automatic expect_strobes(input string name);
        int n;
        foreach (exp_bytes[k]) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (io_we !== 1'b1 && n < 300);
            if (io_we !== 1'b1)
                stop_with_error($sformatf("%s: no output strobe %0d within 300 cycles", name, k));
            check({24'd0, io_data}, {24'd0, exp_bytes[k]}, $sformatf("%s strobe %0d", name, k));
        end
        repeat (50) begin
            @(negedge clk);
            if (io_we === 1'b1)
                stop_with_error($sformatf("%s: unexpected extra output strobe", name));
        end
    endtask

    task automatic reset_fetch();
        prog = {i_type(OPC_ADDI, 0, 1, 'h5a), store_io(1)};
        exp_bytes = {8'h5a};
        start_program();
        check(instr_addr, 32'd0, "first fetch address");
        @(negedge clk);
        check(instr_addr, 32'd4, "PC after first fetch");
        repeat (3) @(negedge clk); // Rest of the 4-cycle addi
        check(instr_addr, 32'd4, "second fetch address");
        @(negedge clk);
        check(instr_addr, 32'd8, "PC after second fetch");
        expect_strobes("reset");
    endtask

    task automatic alu_ops();
        int a;
        int b;
        a = -90;
        b = 37;
        prog = {i_type(OPC_ADDI, 0, 1, a), i_type(OPC_ADDI, 0, 2, b),
                r_type(1, 2, 3, FN_ADD), store_io(3), r_type(1, 2, 3, FN_SUB), store_io(3),
                r_type(1, 2, 3, FN_AND), store_io(3), r_type(1, 2, 3, FN_OR), store_io(3),
                r_type(1, 2, 3, FN_SLT), store_io(3)};
        exp_bytes = {8'(a + b), 8'(a - b), 8'(a & b), 8'(a | b), 8'((a < b) ? 1 : 0)};
        start_program();
        expect_strobes("arithmetic");
    endtask

    task automatic load_store();
        prog = {i_type(OPC_ADDI, 0, 1, 55), i_type(OPC_ADDI, 0, 2, 200),
                i_type(OPC_SW, 0, 1, 8), i_type(OPC_SW, 0, 2, 20),
                i_type(OPC_SW, 0, 1, 0),                              // RAM word under the port index
                i_type(OPC_LW, 0, 3, 8), i_type(OPC_LW, 0, 4, 20),
                r_type(3, 4, 5, FN_ADD), store_io(5),
                i_type(OPC_ADDI, 0, 0, 77), store_io(0),              // $zero stays 0
                i_type(OPC_LW, 0, 7, `MIPS_IO_ADDR), store_io(7)};   // Port reads as 0
        exp_bytes = {8'(55 + 200), 8'd0, 8'd0};
        start_program();
        expect_strobes("memory");
    endtask

    task automatic branch_paths();
        prog = {i_type(OPC_ADDI, 0, 1, 5), i_type(OPC_ADDI, 0, 2, 5),
                i_type(OPC_ADDI, 0, 3, 9),
                i_type(OPC_BEQ, 1, 2, 1), store_io(3),               // Taken branch skips the store
                i_type(OPC_ADDI, 0, 4, 'h11), i_type(OPC_BEQ, 1, 3, 1), store_io(4),
                i_type(OPC_ADDI, 0, 4, 'h22), store_io(4)};
        exp_bytes = {8'h11, 8'h22};
        start_program();
        expect_strobes("branch");
    endtask

    task automatic jump_forward();
        prog = {i_type(OPC_ADDI, 0, 1, 'h33), i_type(OPC_ADDI, 0, 2, 'h44),
                j_type(4), store_io(1), store_io(2)};
        exp_bytes = {8'h44};
        start_program();
        expect_strobes("jump");
    endtask

    task automatic random_chain();
        logic [15:0] imm;
        int acc;
        prog = {};
        exp_bytes = {};
        imm = 16'($random(seed));
        acc = int'($signed(imm));
        prog.push_back(i_type(OPC_ADDI, 0, 1, imm));
        prog.push_back(store_io(1));
        exp_bytes.push_back(8'(acc));
        for (int k = 1; k < 6; k++) begin
            imm = 16'($random(seed));
            prog.push_back(i_type(OPC_ADDI, 0, 2, imm));
            prog.push_back(r_type(1, 2, 1, (k % 2) ? FN_ADD : FN_SUB)); // Alternate add/sub
            prog.push_back(store_io(1));
            acc = (k % 2) ? acc + int'($signed(imm)) : acc - int'($signed(imm));
            exp_bytes.push_back(8'(acc));
        end
        start_program();
        expect_strobes("random");
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        seed  = 89389;
        foreach (rom[i]) rom[i] = {6'h3f, 18'h0, 8'(i)};
        reset_fetch();
        alu_ops();
        load_store();
        branch_paths();
        jump_forward();
        random_chain();
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog sized for all tests
    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog timeout, the tests did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: project.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_control.sv
verilog/mips_datapath.sv
verilog/mips_data_mem.sv
verilog/mips_top.sv
test/tb_mips.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_mips
FILELIST  = project.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
